// File: src/pkg_tpu.sv
package pkg_tpu;

	// requestors per direction
	localparam int NUM_PORT = 3;

	localparam int ADDR_W = 16;
	localparam int PORT_W = 2;

	// base address of one tile
	typedef logic [ADDR_W-1:0] address_t;

	// requestor number, 0 to NUM_PORT-1
	typedef logic [PORT_W-1:0] port_no_t;

	// transfer direction
	typedef enum logic {
		op_store = 1'b0,
		op_load  = 1'b1
	} op_t;

endpackage

// File: src/pub_grant_if.sv
`timescale 1ns/10ps

interface pub_grant_if;
	import pkg_tpu::*;

	logic     grant_vld;	// level, held until xfer_end
	port_no_t grant_no;
	address_t base;		// base of the granted port
	logic     ready;		// from the domain table
	logic     xfer_end;	// one-cycle pulse

	modport arb (
		output grant_vld,
		output grant_no,
		output base,
		input  xfer_end
	);

	modport man (
		input  grant_vld,
		input  grant_no,
		input  base,
		input  xfer_end,
		output ready
	);

	modport seq (
		input  grant_vld,
		input  grant_no,
		input  ready,
		output xfer_end
	);

endinterface

// File: src/pub_grant_arb.sv
`timescale 1ns/10ps

module pub_grant_arb (
	input  logic                         clock,
	input  logic                         reset,
	input  logic [pkg_tpu::NUM_PORT-1:0] req,
	input  pkg_tpu::address_t            base [pkg_tpu::NUM_PORT],
	pub_grant_if.arb                     bus
);
	import pkg_tpu::*;

	port_no_t last_no;	// last port granted
	port_no_t pick_no;
	logic     pick_vld;

	// round robin, search starts just after the last grant
	always_comb begin
		int idx;

		pick_vld = 1'b0;
		pick_no = '0;
		for (int k = 1; k <= NUM_PORT; k++) begin
			idx = (int'(last_no) + k) % NUM_PORT;
			if (!pick_vld && req[idx]) begin
				pick_vld = 1'b1;
				pick_no = port_no_t'(idx);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bus.grant_vld <= 1'b0;
			last_no <= port_no_t'(NUM_PORT - 1);	// port 0 goes first
		end
		else if (bus.grant_vld) begin
			if (bus.xfer_end) begin
				bus.grant_vld <= 1'b0;
			end
		end
		else if (pick_vld) begin
			bus.grant_vld <= 1'b1;
			last_no <= pick_no;
		end
	end

	// number and base stay latched for the whole grant
	always_ff @(posedge clock) begin
		if (!bus.grant_vld && pick_vld) begin
			bus.grant_no <= pick_no;
			bus.base <= base[pick_no];
		end
	end

endmodule

// File: src/pub_xfer_seq.sv
`timescale 1ns/10ps

module pub_xfer_seq #(
	parameter int XFER_BEATS = 4
)(
	input  logic                         clock,
	input  logic                         reset,
	pub_grant_if.seq                     bus,
	output logic [pkg_tpu::NUM_PORT-1:0] done
);
	import pkg_tpu::*;

	localparam int CNT_W = (XFER_BEATS > 1) ? $clog2(XFER_BEATS) : 1;

	logic             busy;
	logic             armed;	// grant has been low since the last start
	logic             start;
	logic             last_beat;
	logic [CNT_W-1:0] beat_cnt;

	// ready only matters here, not during the beats
	assign start = bus.grant_vld & bus.ready & armed & ~busy;
	assign last_beat = busy & (beat_cnt == CNT_W'(XFER_BEATS - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end
		else if (start) begin
			busy <= 1'b1;
		end
		else if (last_beat) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			beat_cnt <= '0;
		end
		else if (start) begin
			beat_cnt <= '0;
		end
		else if (busy) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// no restart on a grant that is still held from the last transfer
	always_ff @(posedge clock) begin
		if (reset) begin
			armed <= 1'b1;
		end
		else if (start) begin
			armed <= 1'b0;
		end
		else if (!bus.grant_vld) begin
			armed <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bus.xfer_end <= 1'b0;
			done <= '0;
		end
		else begin
			bus.xfer_end <= last_beat;
			if (last_beat) begin
				done <= NUM_PORT'(1) << bus.grant_no;	// one-hot per port
			end
			else begin
				done <= '0;
			end
		end
	end

endmodule

// File: src/pub_domain_man.sv
`timescale 1ns/10ps

module pub_domain_man #(
	parameter int NUM_ENTRY = 8
)(
	input  logic     clock,
	input  logic     reset,
	pub_grant_if.man st_bus,
	pub_grant_if.man ld_bus
);
	import pkg_tpu::*;

	localparam int IDX_W = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1;

	address_t             tab_base [NUM_ENTRY];
	logic [NUM_ENTRY-1:0] valid;
	logic [NUM_ENTRY-1:0] stored;

	logic                 st_vld_q;
	logic                 st_rise;
	logic                 st_alloc;
	logic                 st_end;
	logic                 ld_end;

	logic [NUM_ENTRY-1:0] st_hit_vec;
	logic [NUM_ENTRY-1:0] ld_hit_vec;
	logic                 st_hit;
	logic                 ld_hit;
	logic                 any_free;
	logic [IDX_W-1:0]     st_hit_idx;
	logic [IDX_W-1:0]     ld_hit_idx;
	logic [IDX_W-1:0]     free_idx;

	logic [IDX_W-1:0]     st_idx_q;	// entry bound to the store grant
	logic [IDX_W-1:0]     ld_idx_q;	// entry bound to the load grant

	assign st_rise = st_bus.grant_vld & ~st_vld_q;
	assign st_end = st_bus.grant_vld & st_bus.xfer_end;
	assign ld_end = ld_bus.grant_vld & ld_bus.xfer_end;

	// exact base match, load needs the stored flag too
	always_comb begin
		for (int i = 0; i < NUM_ENTRY; i++) begin
			st_hit_vec[i] = valid[i] & (tab_base[i] == st_bus.base);
			ld_hit_vec[i] = valid[i] & stored[i] & (tab_base[i] == ld_bus.base);
		end
	end

	// lowest index wins, so scan downward
	always_comb begin
		st_hit = 1'b0;
		ld_hit = 1'b0;
		any_free = 1'b0;
		st_hit_idx = '0;
		ld_hit_idx = '0;
		free_idx = '0;
		for (int i = NUM_ENTRY - 1; i >= 0; i--) begin
			if (st_hit_vec[i]) begin
				st_hit = 1'b1;
				st_hit_idx = IDX_W'(i);
			end
			if (ld_hit_vec[i]) begin
				ld_hit = 1'b1;
				ld_hit_idx = IDX_W'(i);
			end
			if (!valid[i]) begin
				any_free = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
	end

	// on the rising grant, or later once a blocked store finds room
	assign st_alloc = st_bus.grant_vld & ~st_hit & any_free;

	assign st_bus.ready = st_bus.grant_vld & (st_hit ? ~stored[st_hit_idx] : any_free);
	assign ld_bus.ready = ld_bus.grant_vld & ld_hit;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_vld_q <= 1'b0;
		end
		else begin
			st_vld_q <= st_bus.grant_vld;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			stored <= '0;
		end
		else begin
			if (st_alloc) begin
				valid[free_idx] <= 1'b1;
				stored[free_idx] <= 1'b0;
			end
			if (st_end) begin
				stored[st_idx_q] <= 1'b1;
			end
			if (ld_end) begin	// consumed, entry is free again
				valid[ld_idx_q] <= 1'b0;
				stored[ld_idx_q] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (st_alloc) begin
			tab_base[free_idx] <= st_bus.base;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			st_idx_q <= '0;
		end
		else if (st_alloc) begin
			st_idx_q <= free_idx;
		end
		else if (st_rise && st_hit) begin
			st_idx_q <= st_hit_idx;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_idx_q <= '0;
		end
		else if (ld_bus.grant_vld && ld_hit) begin
			ld_idx_q <= ld_hit_idx;
		end
	end

endmodule

// File: src/pub_domain_top.sv
`timescale 1ns/10ps

module pub_domain_top #(
	parameter int NUM_ENTRY  = 8,
	parameter int XFER_BEATS = 4
)(
	input  logic                         clock,
	input  logic                         reset,

	// store requestors
	input  logic [pkg_tpu::NUM_PORT-1:0] st_req,
	input  pkg_tpu::address_t            st_base [pkg_tpu::NUM_PORT],

	// load requestors
	input  logic [pkg_tpu::NUM_PORT-1:0] ld_req,
	input  pkg_tpu::address_t            ld_base [pkg_tpu::NUM_PORT],

	output logic [pkg_tpu::NUM_PORT-1:0] st_done,
	output logic [pkg_tpu::NUM_PORT-1:0] ld_done
);

	pub_grant_if st_bus ();
	pub_grant_if ld_bus ();

	// store side
	pub_grant_arb st_arb_inst (
		.clock (clock),
		.reset (reset),
		.req   (st_req),
		.base  (st_base),
		.bus   (st_bus.arb)
	);

	pub_xfer_seq #(
		.XFER_BEATS (XFER_BEATS)
	) st_seq_inst (
		.clock (clock),
		.reset (reset),
		.bus   (st_bus.seq),
		.done  (st_done)
	);

	// load side
	pub_grant_arb ld_arb_inst (
		.clock (clock),
		.reset (reset),
		.req   (ld_req),
		.base  (ld_base),
		.bus   (ld_bus.arb)
	);

	pub_xfer_seq #(
		.XFER_BEATS (XFER_BEATS)
	) ld_seq_inst (
		.clock (clock),
		.reset (reset),
		.bus   (ld_bus.seq),
		.done  (ld_done)
	);

	// shared table, gates both directions
	pub_domain_man #(
		.NUM_ENTRY (NUM_ENTRY)
	) domain_man_inst (
		.clock  (clock),
		.reset  (reset),
		.st_bus (st_bus.man),
		.ld_bus (ld_bus.man)
	);

endmodule

// File: tests/tb_pub_domain.sv
`timescale 1ns/10ps

module tb_pub_domain;
	import pkg_tpu::*;

	localparam int NUM_ENTRY    = 4;
	localparam int XFER_BEATS   = 4;
	localparam int NUM_DIRECTED = 20;
	localparam int NUM_BATCH    = 4;
	localparam int NUM_ROWS     = NUM_DIRECTED + NUM_BATCH * 2 * NUM_PORT;
	localparam int PEND_WAIT    = XFER_BEATS + 8;
	localparam int TIMEOUT      = NUM_ROWS * (XFER_BEATS + 8) * 4;

	localparam logic [1:0] OUT_DONE = 2'd0;	// wait for the done pulse
	localparam logic [1:0] OUT_PEND = 2'd1;	// still open after PEND_WAIT
	localparam logic [1:0] OUT_ANY  = 2'd2;	// reference model only

	typedef struct packed {
		op_t        op;
		port_no_t   port;
		address_t   base;
		logic [3:0] delay;	// cycles before issue
		logic [1:0] outcome;
	} row_t;

	logic                clock;
	logic                reset;
	logic [NUM_PORT-1:0] st_req;
	address_t            st_base [NUM_PORT];
	logic [NUM_PORT-1:0] ld_req;
	address_t            ld_base [NUM_PORT];
	logic [NUM_PORT-1:0] st_done;
	logic [NUM_PORT-1:0] ld_done;

	row_t     rows [NUM_ROWS];
	logic     open_flag [2][NUM_PORT];	// indexed by op, then port
	address_t open_base [2][NUM_PORT];
	address_t model_stored [$];	// bases whose data is in the buffer
	int       model_free;
	int       seed = 93;
	int       errors = 0;
	int       n_done = 0;
	int       cycle_cnt = 0;

	pub_domain_top #(
		.NUM_ENTRY  (NUM_ENTRY),
		.XFER_BEATS (XFER_BEATS)
	) pub_domain_top_inst (
		.clock   (clock),
		.reset   (reset),
		.st_req  (st_req),
		.st_base (st_base),
		.ld_req  (ld_req),
		.ld_base (ld_base),
		.st_done (st_done),
		.ld_done (ld_done)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("timeout: requests still open after %0d cycles", cycle_cnt);
			$display("rows %0d, done pulses %0d, errors %0d", NUM_ROWS, n_done, errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic int find_stored(input address_t base);
		for (int i = 0; i < model_stored.size(); i++) begin
			if (model_stored[i] == base) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic logic any_open();
		logic busy;

		busy = 1'b0;
		for (int p = 0; p < NUM_PORT; p++) begin
			busy = busy | open_flag[0][p] | open_flag[1][p];
		end
		return busy;
	endfunction

	// a done must follow the domain rules before the model moves on
	task automatic check_done(input op_t op, input port_no_t port, input address_t base);
		int idx;

		idx = find_stored(base);
		if (op == op_store) begin
			if (idx >= 0) begin
				errors++;
				$display("[ERROR] st_done[%0d]: base 0x%h ended while still stored", port, base);
			end
			else if (model_free == 0) begin
				errors++;
				$display("[ERROR] st_done[%0d]: base 0x%h ended with free entries 0x%h",
					port, base, model_free);
			end
			else begin
				model_stored.push_back(base);
				model_free--;
			end
		end
		else if (idx < 0) begin
			errors++;
			$display("[ERROR] ld_done[%0d]: base 0x%h ended before its store", port, base);
		end
		else begin
			model_stored.delete(idx);	// consumed
			model_free++;
		end
	endtask

	task automatic check_pending(input op_t op, input port_no_t port);
		if (!open_flag[op][port]) begin
			errors++;
			$display("[ERROR] %s[%0d]: base 0x%h ended, expected pending 0x1",
				(op == op_store) ? "st_done" : "ld_done", port, open_base[op][port]);
		end
	endtask

	task automatic handle_done(input op_t op, input int p);
		if (!open_flag[op][p]) begin
			errors++;
			$display("%s port %0d pulsed done without an open request",
				(op == op_store) ? "store" : "load ", p);
		end
		else begin
			check_done(op, port_no_t'(p), open_base[op][p]);
			open_flag[op][p] = 1'b0;
			n_done++;
			if (op == op_store) begin
				st_req[p] <= 1'b0;
			end
			else begin
				ld_req[p] <= 1'b0;
			end
		end
	endtask

	// done bits are registered and read before this edge updates them
	task automatic step_cycle();
		@(posedge clock);
		for (int p = 0; p < NUM_PORT; p++) begin
			if (st_done[p]) begin
				handle_done(op_store, p);
			end
			if (ld_done[p]) begin
				handle_done(op_load, p);
			end
		end
	endtask

	task automatic drain_all();
		while (any_open()) begin
			step_cycle();
		end
	endtask

	task automatic issue_row(input row_t row);
		while (open_flag[row.op][row.port]) begin
			step_cycle();
		end
		repeat (row.delay) step_cycle();	// a delay of at least 1 keeps req low a cycle
		if (row.op == op_store) begin
			st_req[row.port] <= 1'b1;
			st_base[row.port] <= row.base;
		end
		else begin
			ld_req[row.port] <= 1'b1;
			ld_base[row.port] <= row.base;
		end
		open_flag[row.op][row.port] = 1'b1;
		open_base[row.op][row.port] = row.base;
	endtask

	task automatic run_row(input row_t row);
		issue_row(row);
		if (row.outcome == OUT_DONE) begin
			while (open_flag[row.op][row.port]) begin
				step_cycle();
			end
		end
		else if (row.outcome == OUT_PEND) begin
			repeat (PEND_WAIT) step_cycle();
			check_pending(row.op, row.port);
		end
	endtask

	task automatic set_row(input int i, input op_t op, input int port, input address_t base,
		input int delay, input logic [1:0] outcome);
		rows[i].op = op;
		rows[i].port = port_no_t'(port);
		rows[i].base = base;
		rows[i].delay = 4'(delay);
		rows[i].outcome = outcome;
	endtask

	task automatic load_directed_rows();
		set_row(0, op_store, 0, 16'h1000, 1, OUT_DONE);	// fresh base
		set_row(1, op_load,  0, 16'h1000, 1, OUT_DONE);
		set_row(2, op_load,  1, 16'h2000, 1, OUT_PEND);	// load ahead of its store
		set_row(3, op_store, 1, 16'h2000, 2, OUT_DONE);
		set_row(4, op_load,  2, 16'h2000, 1, OUT_PEND);	// already consumed
		set_row(5, op_store, 2, 16'h2000, 1, OUT_DONE);
		set_row(6, op_store, 0, 16'h3000, 1, OUT_DONE);
		set_row(7, op_store, 1, 16'h3000, 1, OUT_PEND);	// still stored
		set_row(8, op_load,  0, 16'h3000, 1, OUT_DONE);
		set_row(9, op_load,  1, 16'h3000, 1, OUT_DONE);
		// fill all four entries
		set_row(10, op_store, 0, 16'h4000, 1, OUT_DONE);
		set_row(11, op_store, 1, 16'h4100, 1, OUT_DONE);
		set_row(12, op_store, 2, 16'h4200, 1, OUT_DONE);
		set_row(13, op_store, 0, 16'h4300, 1, OUT_DONE);
		set_row(14, op_store, 1, 16'h4400, 1, OUT_PEND);	// no free entry
		set_row(15, op_load,  2, 16'h4100, 1, OUT_DONE);
		set_row(16, op_load,  0, 16'h4000, 1, OUT_DONE);
		set_row(17, op_load,  1, 16'h4200, 1, OUT_DONE);
		set_row(18, op_load,  2, 16'h4300, 1, OUT_DONE);
		set_row(19, op_load,  0, 16'h4400, 1, OUT_DONE);
	endtask

	// each batch holds three stores and three loads of the same three bases
	task automatic load_random_rows();
		address_t    bases [NUM_PORT];
		logic [31:0] rnd;
		int          rot;
		int          i;

		i = NUM_DIRECTED;
		for (int b = 0; b < NUM_BATCH; b++) begin
			for (int k = 0; k < NUM_PORT; k++) begin
				rnd = $random(seed);
				bases[k] = (address_t'(k) << 14) | address_t'(rnd[13:0]);	// distinct per k
			end
			rot = $unsigned($random(seed)) % NUM_PORT;
			for (int k = 0; k < NUM_PORT; k++) begin
				set_row(i, op_store, k, bases[k], 1 + $unsigned($random(seed)) % 2, OUT_ANY);
				set_row(i + 1, op_load, k, bases[(k + rot) % NUM_PORT],
					1 + $unsigned($random(seed)) % 2, OUT_ANY);
				i += 2;
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		st_req = '0;
		ld_req = '0;
		for (int p = 0; p < NUM_PORT; p++) begin
			st_base[p] = '0;
			ld_base[p] = '0;
			open_flag[0][p] = 1'b0;
			open_flag[1][p] = 1'b0;
		end
		model_free = NUM_ENTRY;
		load_directed_rows();
		load_random_rows();

		repeat (5) @(posedge clock);
		reset <= 1'b0;

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (i >= NUM_DIRECTED && (i - NUM_DIRECTED) % (2 * NUM_PORT) == 0) begin
				drain_all();	// batch starts on an empty table
			end
			run_row(rows[i]);
		end
		drain_all();
		repeat (PEND_WAIT) step_cycle();	// stray done pulses

		$display("rows %0d, done pulses %0d, errors %0d", NUM_ROWS, n_done, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: pub_domain.f
src/pkg_tpu.sv
src/pub_grant_if.sv
src/pub_grant_arb.sv
src/pub_xfer_seq.sv
src/pub_domain_man.sv
src/pub_domain_top.sv
tests/tb_pub_domain.sv

// File: Bender.yml
package:
  name: pub_domain

sources:
  - src/pkg_tpu.sv
  - src/pub_grant_if.sv
  - src/pub_grant_arb.sv
  - src/pub_xfer_seq.sv
  - src/pub_domain_man.sv
  - src/pub_domain_top.sv
  - target: test
    files:
      - tests/tb_pub_domain.sv
